// ==== hw/tcp_ack_defines.svh ====
//////////////////////////////////////////////////////////////////////
// tcp ack path defaults
// timer length, forced-ack segment count and advertised window
//////////////////////////////////////////////////////////////////////

`ifndef TCP_ACK_DEFINES_SVH
`define TCP_ACK_DEFINES_SVH

// ack timer length in clock cycles
`define ACK_TIMEOUT_DEF 1250

// unacked segments that force a pure ack without waiting for the timer
`define FORCE_ACK_PKTS_DEF 5

// receive window advertised in every pure ack (bytes)
`define ACK_WINDOW 16'h2000

`endif

// ==== hw/tcp_ack_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// tcp ack package
// number, length and port types shared by the ack pipeline stages
//////////////////////////////////////////////////////////////////////

package tcp_ack_pkg;

  typedef logic [31:0] tcp_num_t;  // seq / ack number, modulo 2^32
  typedef logic [15:0] tcp_len_t;  // payload length in bytes
  typedef logic [15:0] tcp_port_t; // tcp port number

  //////////////////////////////////////////////////////////////////////
  // serial number arithmetic
  //////////////////////////////////////////////////////////////////////

  // true when a is strictly ahead of b
  // nonzero difference with msb clear, so wrap past ffffffff is handled
  function automatic logic tcp_seq_ahead(
    input tcp_num_t a,
    input tcp_num_t b
  );
    tcp_num_t diff;
    diff = a - b;
    return (diff != '0) && !diff[31];
  endfunction

endpackage : tcp_ack_pkg

// ==== hw/tcp_rx_meta.sv ====
//////////////////////////////////////////////////////////////////////
// rx meta stage
// drops segments for other ports, computes end sequence of the rest
//////////////////////////////////////////////////////////////////////

module tcp_rx_meta
  import tcp_ack_pkg::*;
(
  input  logic      clk,
  input  logic      rst,

  // segment header fields from the parser
  input  logic      seg_val,      // one-cycle strobe
  input  tcp_num_t  seg_seq,
  input  tcp_len_t  seg_len,
  input  logic      seg_syn,
  input  logic      seg_fin,
  input  tcp_port_t seg_dst_port,

  input  tcp_port_t local_port,   // our port, level

  // to ack control
  output logic      meta_val,     // accepted segment
  output logic      meta_sof,     // start of segment, counts toward forced ack
  output tcp_num_t  meta_end_seq  // first seq after this segment
);

  logic     accept;
  tcp_num_t seg_span; // sequence space consumed
  tcp_num_t end_seq;

  //////////////////////////////////////////////////////////////////////
  // port filter and end sequence
  //////////////////////////////////////////////////////////////////////

  assign accept = seg_val && (seg_dst_port == local_port);

  // syn and fin each take one number of sequence space
  assign seg_span = tcp_num_t'(seg_len)
                  + tcp_num_t'(seg_syn)
                  + tcp_num_t'(seg_fin);

  assign end_seq = seg_seq + seg_span; // wraps naturally mod 2^32

  //////////////////////////////////////////////////////////////////////
  // stage register
  //////////////////////////////////////////////////////////////////////

  // strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      meta_val <= 1'b0;
      meta_sof <= 1'b0;
    end else begin
      meta_val <= accept;
      meta_sof <= accept; // one sof per accepted segment
    end
  end

  // payload, only loaded for accepted segments
  always_ff @(posedge clk) begin
    if (accept) meta_end_seq <= end_seq;
  end

endmodule : tcp_rx_meta

// ==== hw/tcp_ack_ctrl.sv ====
//////////////////////////////////////////////////////////////////////
// ack control stage
// keeps the local ack number and requests a pure ack on timeout
// or after too many unacknowledged segments
//////////////////////////////////////////////////////////////////////

`include "tcp_ack_defines.svh"

module tcp_ack_ctrl
  import tcp_ack_pkg::*;
#(
  parameter int TIMEOUT           = `ACK_TIMEOUT_DEF,   // ack timer, clock cycles
  parameter int FORCE_ACK_PACKETS = `FORCE_ACK_PKTS_DEF // segments before forced ack
)
(
  input  logic     clk,
  input  logic     rst,

  input  logic     connected,    // connection established, level
  input  logic     init,         // load loc_ack from init_ack
  input  tcp_num_t init_ack,

  // from rx meta
  input  logic     meta_val,
  input  logic     meta_sof,
  input  tcp_num_t meta_end_seq,

  // from ack tx
  input  tcp_num_t last_ack,     // ack the peer has been given
  input  logic     sent,         // descriptor issued

  output tcp_num_t loc_ack,      // current local ack number
  output logic     send          // pure ack request, held until sent
);

  localparam int TMR_W = $clog2(TIMEOUT + 1);
  localparam int CNT_W = $clog2(FORCE_ACK_PACKETS + 1);

  logic [TMR_W-1:0] timer;
  logic [CNT_W-1:0] unacked_pkts;

  logic acked;       // nothing new to acknowledge
  logic upd_loc_ack; // segment end is ahead of loc_ack
  logic timeout_ack;
  logic pkts_ack;

  //////////////////////////////////////////////////////////////////////
  // local ack
  //////////////////////////////////////////////////////////////////////

  // old and reordered segments must not pull loc_ack back
  assign upd_loc_ack = tcp_seq_ahead(meta_end_seq, loc_ack);

  always_ff @(posedge clk) begin
    if (rst) begin
      loc_ack <= '0;
    end else if (init) begin
      loc_ack <= init_ack; // handshake value wins over data
    end else if (meta_val && upd_loc_ack) begin
      loc_ack <= meta_end_seq;
    end
  end

  assign acked = (loc_ack == last_ack);

  //////////////////////////////////////////////////////////////////////
  // unacked segment counter
  //////////////////////////////////////////////////////////////////////

  assign pkts_ack = (unacked_pkts == CNT_W'(FORCE_ACK_PACKETS)); // limit hit

  always_ff @(posedge clk) begin
    if (rst) begin
      unacked_pkts <= '0;
    end else if (acked) begin
      unacked_pkts <= '0; // peer is up to date
    end else if (connected) begin
      if (sent) unacked_pkts <= '0;
      else if (meta_sof && !pkts_ack) unacked_pkts <= unacked_pkts + 1'b1; // saturate
    end
  end

  //////////////////////////////////////////////////////////////////////
  // ack timer
  //////////////////////////////////////////////////////////////////////

  // fires once on the way up, timer then sits at TIMEOUT
  assign timeout_ack = (timer == TMR_W'(TIMEOUT - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      timer <= '0;
    end else if (acked) begin
      timer <= '0;
    end else if (connected) begin
      if (meta_val) timer <= '0;                                  // restart on new data
      else if (timer != TMR_W'(TIMEOUT)) timer <= timer + 1'b1;  // count up, then hold
    end
  end

  //////////////////////////////////////////////////////////////////////
  // send request
  //////////////////////////////////////////////////////////////////////

  // sent first, so a still-full counter cannot re-arm send on the same edge
  always_ff @(posedge clk) begin
    if (rst) begin
      send <= 1'b0;
    end else if (sent) begin
      send <= 1'b0;
    end else if (timeout_ack || pkts_ack) begin
      send <= 1'b1;
    end
  end

endmodule : tcp_ack_ctrl

// ==== hw/tcp_ack_tx.sv ====
//////////////////////////////////////////////////////////////////////
// ack tx stage
// issues one pure-ack descriptor per request once tx is free
// and remembers the last ack number sent
//////////////////////////////////////////////////////////////////////

`include "tcp_ack_defines.svh"

module tcp_ack_tx
  import tcp_ack_pkg::*;
(
  input  logic     clk,
  input  logic     rst,

  input  logic     init,         // load last_ack along with loc_ack
  input  tcp_num_t init_ack,

  input  logic     send,         // request from ack control, level
  input  tcp_num_t loc_ack,
  input  tcp_num_t loc_seq,      // our current seq, goes into the ack
  input  logic     tx_busy,      // transmitter occupied

  output logic     sent,         // pulse back to ack control
  output tcp_num_t last_ack,     // ack of the most recent descriptor

  // pure ack descriptor to the transmitter
  output logic     ack_pkt_val,
  output tcp_num_t ack_pkt_seq,
  output tcp_num_t ack_pkt_ack,
  output tcp_len_t ack_pkt_win
);

  logic holdoff; // one dead cycle while send falls
  logic issue;

  assign issue = send && !tx_busy && !holdoff;

  //////////////////////////////////////////////////////////////////////
  // strobes and holdoff
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_pkt_val <= 1'b0;
      sent        <= 1'b0;
      holdoff     <= 1'b0;
    end else begin
      ack_pkt_val <= issue;
      sent        <= issue;
      holdoff     <= issue; // send still high the cycle after issue
    end
  end

  // last acknowledged value seen by the peer
  always_ff @(posedge clk) begin
    if (rst) begin
      last_ack <= '0;
    end else if (init) begin
      last_ack <= init_ack; // nothing owed right after init
    end else if (issue) begin
      last_ack <= loc_ack;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // descriptor fields
  //////////////////////////////////////////////////////////////////////

  // loc_ack taken as it stands now, may be newer than the request
  always_ff @(posedge clk) begin
    if (issue) begin
      ack_pkt_seq <= loc_seq;
      ack_pkt_ack <= loc_ack;
      ack_pkt_win <= `ACK_WINDOW;
    end
  end

endmodule : tcp_ack_tx

// ==== hw/tcp_ack_top.sv ====
//////////////////////////////////////////////////////////////////////
// tcp ack path top
// rx meta -> ack control -> ack tx, three stage pipeline
//////////////////////////////////////////////////////////////////////

`include "tcp_ack_defines.svh"

module tcp_ack_top
  import tcp_ack_pkg::*;
#(
  parameter int TIMEOUT           = `ACK_TIMEOUT_DEF,
  parameter int FORCE_ACK_PACKETS = `FORCE_ACK_PKTS_DEF
)
(
  input  logic      clk,
  input  logic      rst,

  // parsed segment headers
  input  logic      seg_val,
  input  tcp_num_t  seg_seq,
  input  tcp_len_t  seg_len,
  input  logic      seg_syn,
  input  logic      seg_fin,
  input  tcp_port_t seg_dst_port,

  // connection context
  input  tcp_port_t local_port,
  input  logic      connected,
  input  logic      init,
  input  tcp_num_t  init_ack,
  input  tcp_num_t  loc_seq,

  input  logic      tx_busy,

  output tcp_num_t  loc_ack,

  // pure ack descriptor
  output logic      ack_pkt_val,
  output tcp_num_t  ack_pkt_seq,
  output tcp_num_t  ack_pkt_ack,
  output tcp_len_t  ack_pkt_win
);

  // stage 1 -> 2
  logic     meta_val;
  logic     meta_sof;
  tcp_num_t meta_end_seq;

  // stage 2 <-> 3
  logic     send;
  logic     sent;
  tcp_num_t last_ack;

  tcp_rx_meta tcp_rx_meta_inst (
    .clk          (clk),
    .rst          (rst),
    .seg_val      (seg_val),
    .seg_seq      (seg_seq),
    .seg_len      (seg_len),
    .seg_syn      (seg_syn),
    .seg_fin      (seg_fin),
    .seg_dst_port (seg_dst_port),
    .local_port   (local_port),
    .meta_val     (meta_val),
    .meta_sof     (meta_sof),
    .meta_end_seq (meta_end_seq)
  );

  tcp_ack_ctrl #(
    .TIMEOUT           (TIMEOUT),
    .FORCE_ACK_PACKETS (FORCE_ACK_PACKETS)
  ) tcp_ack_ctrl_inst (
    .clk          (clk),
    .rst          (rst),
    .connected    (connected),
    .init         (init),
    .init_ack     (init_ack),
    .meta_val     (meta_val),
    .meta_sof     (meta_sof),
    .meta_end_seq (meta_end_seq),
    .last_ack     (last_ack),
    .sent         (sent),
    .loc_ack      (loc_ack),
    .send         (send)
  );

  tcp_ack_tx tcp_ack_tx_inst (
    .clk         (clk),
    .rst         (rst),
    .init        (init),
    .init_ack    (init_ack),
    .send        (send),
    .loc_ack     (loc_ack),
    .loc_seq     (loc_seq),
    .tx_busy     (tx_busy),
    .sent        (sent),
    .last_ack    (last_ack),
    .ack_pkt_val (ack_pkt_val),
    .ack_pkt_seq (ack_pkt_seq),
    .ack_pkt_ack (ack_pkt_ack),
    .ack_pkt_win (ack_pkt_win)
  );

endmodule : tcp_ack_top

// ==== testbench/tb_clk_gen.sv ====
//////////////////////////////////////////////////////////////////////
// testbench clock and reset
// 20 ns clock, reset high for the first 8 cycles
//////////////////////////////////////////////////////////////////////

module tb_clk_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0; // release just after the edge, like the stimulus
  end

endmodule : tb_clk_gen

// ==== testbench/tcp_ack_checker.sv ====
//////////////////////////////////////////////////////////////////////
// tcp ack path checker
// reference model of the expected ack and concurrent assertions
// on loc_ack and the pure-ack descriptor, bound to the top level
//////////////////////////////////////////////////////////////////////

`include "tcp_ack_defines.svh"

module tcp_ack_checker
  import tcp_ack_pkg::*;
#(
  parameter int TIMEOUT           = `ACK_TIMEOUT_DEF,
  parameter int FORCE_ACK_PACKETS = `FORCE_ACK_PKTS_DEF
)
(
  input logic      clk,
  input logic      rst,
  input logic      seg_val,
  input tcp_num_t  seg_seq,
  input tcp_len_t  seg_len,
  input logic      seg_syn,
  input logic      seg_fin,
  input tcp_port_t seg_dst_port,
  input tcp_port_t local_port,
  input logic      connected,
  input logic      init,
  input tcp_num_t  init_ack,
  input tcp_num_t  loc_seq,
  input logic      tx_busy,
  input tcp_num_t  loc_ack,
  input logic      ack_pkt_val,
  input tcp_num_t  ack_pkt_seq,
  input tcp_num_t  ack_pkt_ack,
  input tcp_len_t  ack_pkt_win
);
  timeunit 1ns;
  timeprecision 100ps;

  int       err_cnt = 0;  // read by the testbench top
  logic     m_val;        // model of the stage 1 strobe
  tcp_num_t m_end;        // model end sequence
  tcp_num_t model_ack;    // expected loc_ack
  tcp_num_t acked_val;    // ack the peer was last given
  int       seg_since;    // accepted segments while an ack is owed
  int       idle_cnt;     // quiet cycles while an ack is owed
  logic     owed;
  logic     hold_cnt;

  // a strictly ahead of b when the difference is nonzero and positive
  function automatic logic is_ahead(input logic [31:0] a, input logic [31:0] b);
    logic [31:0] d;
    d = a - b;
    return (d != 32'd0) && (d[31] == 1'b0);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  assign owed     = (model_ack != acked_val);
  assign hold_cnt = !connected || tx_busy || !owed || ack_pkt_val || init;

  always_ff @(posedge clk) begin
    if (rst) begin
      m_val     <= 1'b0;
      model_ack <= '0;
      acked_val <= '0;
      seg_since <= 0;
      idle_cnt  <= 0;
    end else begin
      m_val <= seg_val && (seg_dst_port == local_port);
      m_end <= seg_seq + 32'(seg_len) + 32'(seg_syn) + 32'(seg_fin);
      if (init) model_ack <= init_ack;                               // init wins
      else if (m_val && is_ahead(m_end, model_ack)) model_ack <= m_end;
      if (init) acked_val <= init_ack;
      else if (ack_pkt_val) acked_val <= ack_pkt_ack;
      if (hold_cnt) seg_since <= 0;
      else if (m_val) seg_since <= seg_since + 1;
      if (hold_cnt || m_val) idle_cnt <= 0;
      else idle_cnt <= idle_cnt + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////////////////////////

  a_reset_state: assert property (@(posedge clk) $fell(rst) |-> loc_ack == '0 && !ack_pkt_val)
    else begin
      err_cnt++;
      $error("Fail %0t loc_ack got %h ack_pkt_val got %b after reset, exp 0 and 0",
        $time, loc_ack, ack_pkt_val);
    end

  a_init_load: assert property (@(posedge clk) disable iff (rst)
    init |=> loc_ack == $past(init_ack))
    else begin
      err_cnt++;
      $error("Fail %0t loc_ack got %h exp %h after init", $time, loc_ack, $past(init_ack));
    end

  a_loc_ack: assert property (@(posedge clk) disable iff (rst) loc_ack == model_ack)
    else begin
      err_cnt++;
      $error("Fail %0t loc_ack got %h exp %h", $time, loc_ack, model_ack);
    end

  a_pkt_ack: assert property (@(posedge clk) disable iff (rst)
    ack_pkt_val |-> ack_pkt_ack == $past(model_ack))
    else begin
      err_cnt++;
      $error("Fail %0t ack_pkt_ack got %h exp %h", $time, ack_pkt_ack, $past(model_ack));
    end

  a_pkt_seq: assert property (@(posedge clk) disable iff (rst)
    ack_pkt_val |-> ack_pkt_seq == $past(loc_seq))
    else begin
      err_cnt++;
      $error("Fail %0t ack_pkt_seq got %h exp %h", $time, ack_pkt_seq, $past(loc_seq));
    end

  a_pkt_win: assert property (@(posedge clk) disable iff (rst)
    ack_pkt_val |-> ack_pkt_win == `ACK_WINDOW)
    else begin
      err_cnt++;
      $error("Fail %0t ack_pkt_win got %h exp %h", $time, ack_pkt_win, `ACK_WINDOW);
    end

  // every pure ack must tell the peer something new
  a_pkt_new: assert property (@(posedge clk) disable iff (rst)
    ack_pkt_val |-> ack_pkt_ack != acked_val)
    else begin
      err_cnt++;
      $error("pure ack sent with nothing new to acknowledge");
    end

  a_no_busy_pkt: assert property (@(posedge clk) disable iff (rst)
    ack_pkt_val |-> !$past(tx_busy))
    else begin
      err_cnt++;
      $error("pure ack issued while the transmitter was busy");
    end

  a_single_pkt: assert property (@(posedge clk) disable iff (rst) ack_pkt_val |=> !ack_pkt_val)
    else begin
      err_cnt++;
      $error("two pure acks issued back to back");
    end

  // one more segment may still arrive while the forced ack is on its way out
  a_forced: assert property (@(posedge clk) disable iff (rst)
    seg_since <= FORCE_ACK_PACKETS + 1)
    else begin
      err_cnt++;
      $error("too many segments passed without a forced ack");
    end

  a_timeout: assert property (@(posedge clk) disable iff (rst) idle_cnt <= TIMEOUT + 4)
    else begin
      err_cnt++;
      $error("ack timer expired without a pure ack");
    end

endmodule : tcp_ack_checker

// ==== testbench/tb_tcp_ack.sv ====
//////////////////////////////////////////////////////////////////////
// tcp ack path testbench
// drives segments, init and tx back-pressure into the top level
//////////////////////////////////////////////////////////////////////

module tb_tcp_ack;
  import tcp_ack_pkg::*;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int        TIMEOUT    = 40;
  localparam int        FORCE_PKTS = 4;
  localparam tcp_port_t MY_PORT    = 16'd5001;

  logic      clk, rst;
  logic      seg_val, seg_syn, seg_fin, connected, init, tx_busy;
  tcp_num_t  seg_seq, init_ack, loc_seq, loc_ack;
  tcp_len_t  seg_len;
  tcp_port_t seg_dst_port, local_port;
  logic      ack_pkt_val;
  tcp_num_t  ack_pkt_seq, ack_pkt_ack;
  tcp_len_t  ack_pkt_win;

  logic [31:0] lcg_state = 32'hffa0_82b1;
  tcp_num_t    next_seq;  // next in-order sequence number
  int          tests_run, tests_failed, timeouts, mark;

  tb_clk_gen tb_clk_gen_inst (.clk(clk), .rst(rst));

  tcp_ack_top #(.TIMEOUT(TIMEOUT), .FORCE_ACK_PACKETS(FORCE_PKTS)) tcp_ack_top_inst (.*);

  bind tcp_ack_top tcp_ack_checker #(
    .TIMEOUT(TIMEOUT), .FORCE_ACK_PACKETS(FORCE_ACK_PACKETS)
  ) tcp_ack_checker_inst (.*);

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int error_total();
    return tcp_ack_top_inst.tcp_ack_checker_inst.err_cnt + timeouts;
  endfunction

  task automatic wait_for_reset();
    int n;
    n = 0;
    while (rst && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (rst) begin
      timeouts++;
      $display("reset was never released");
    end
  endtask

  task automatic idle(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic drive_seg(input tcp_num_t seq, input tcp_len_t len,
                           input logic syn, input logic fin, input tcp_port_t port);
    @(posedge clk);
    #1;
    seg_val      = 1'b1;
    seg_seq      = seq;
    seg_len      = len;
    seg_syn      = syn;
    seg_fin      = fin;
    seg_dst_port = port;
    @(posedge clk);
    #1;
    seg_val = 1'b0;
  endtask

  // in-order segment on our port, advances the expected sequence
  task automatic send_next(input tcp_len_t len, input logic syn, input logic fin);
    drive_seg(next_seq, len, syn, fin, MY_PORT);
    next_seq = next_seq + 32'(len) + 32'(syn) + 32'(fin);
    loc_seq  = loc_seq + 32'd1; // keep our own seq moving
  endtask

  task automatic pulse_init(input tcp_num_t v);
    @(posedge clk);
    #1;
    init     = 1'b1;
    init_ack = v;
    @(posedge clk);
    #1;
    init     = 1'b0;
    next_seq = v;
  endtask

  task automatic wait_ack(input int limit, input string what);
    int n;
    n = 0;
    while (!ack_pkt_val && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!ack_pkt_val) begin
      timeouts++;
      $display("no pure ack seen within %0d cycles during %s", limit, what);
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_total() - mark;
    tests_run++;
    if (errs > 0) tests_failed++;
    $display("%0t test %s: %0d errors", $time, name, errs);
    mark = error_total();
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seg_val = 1'b0; seg_syn = 1'b0; seg_fin = 1'b0;
    seg_seq = '0;   seg_len = '0;   seg_dst_port = '0;
    local_port = MY_PORT;
    connected  = 1'b0;
    init       = 1'b0;
    init_ack   = '0;
    loc_seq    = 32'h5555_0000;
    tx_busy    = 1'b0;
    next_seq   = '0;
    tests_run = 0; tests_failed = 0; timeouts = 0; mark = 0;

    // reset and init
    wait_for_reset();
    @(posedge clk);
    #1 connected = 1'b1;
    idle(2);
    pulse_init(32'h1000_0000);
    idle(3);
    finish_test("reset_init");

    // in order, syn and fin each take one number; 3 segments stay under the force limit
    send_next(16'(lcg_next() % 64 + 1), 1'b1, 1'b0);
    send_next(16'(lcg_next() % 64 + 1), 1'b0, 1'b0);
    send_next(16'(lcg_next() % 64 + 1), 1'b0, 1'b1);
    wait_ack(TIMEOUT + 20, "in order advance");
    idle(4);
    finish_test("in_order");

    // other port, stale segment, then wrap past ffffffff
    drive_seg(next_seq, 16'd100, 1'b0, 1'b0, MY_PORT + 16'd1);
    drive_seg(next_seq - 32'd200, 16'd50, 1'b0, 1'b0, MY_PORT);
    idle(4);
    pulse_init(32'hffff_fff0);
    idle(2);
    send_next(16'h20, 1'b0, 1'b0);                         // ends at 0x10
    wait_ack(TIMEOUT + 20, "wraparound advance");
    drive_seg(32'hffff_ffe0, 16'h18, 1'b0, 1'b0, MY_PORT); // ends behind loc_ack
    idle(4);
    finish_test("filtering");

    // back to back segments force acks before the timer
    repeat (9) begin
      send_next(16'(lcg_next() % 32 + 1), 1'b0, 1'b0);
      idle(int'(lcg_next() % 2));
    end
    idle(TIMEOUT + 10); // let any tail ack drain
    finish_test("forced_ack");

    // single segment then silence
    send_next(16'(lcg_next() % 64 + 1), 1'b0, 1'b0);
    wait_ack(TIMEOUT + 10, "timeout ack");
    idle(TIMEOUT + 10);
    finish_test("timeout_ack");

    // transmitter busy while the request builds up
    @(posedge clk);
    #1 tx_busy = 1'b1;
    repeat (6) send_next(16'(lcg_next() % 32 + 1), 1'b0, 1'b0);
    idle(TIMEOUT + 10);
    @(posedge clk);
    #1 tx_busy = 1'b0;
    wait_ack(10, "back-pressure release");
    idle(10);
    finish_test("back_pressure");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_total());
    if (tests_failed == 0 && error_total() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_tcp_ack

// ==== sources.f ====
+incdir+hw
hw/tcp_ack_pkg.sv
hw/tcp_rx_meta.sv
hw/tcp_ack_ctrl.sv
hw/tcp_ack_tx.sv
hw/tcp_ack_top.sv
testbench/tb_clk_gen.sv
testbench/tcp_ack_checker.sv
testbench/tb_tcp_ack.sv
